// ==== compile.f ====
source/kronos_types.sv
source/kronos_alu.sv
source/kronos_decoder.sv
source/kronos_regfile.sv
source/kronos_operand.sv
source/kronos_retire.sv
source/kronos_exec_top.sv
tests/kronos_exec_checker.sv
tests/kronos_exec_tb.sv

// ==== tests/kronos_exec_tb.sv ====
// ==========================================================================
// Kronos execute slice testbench
// ==========================================================================

`timescale 1ns/1ps

module kronos_exec_tb
  import kronos_types::*;
;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        retire_valid;
  logic        retire_illegal;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic [31:0] instret;

  integer seed = 32'hed9c_de37;

  // Reference register state, updated in program order at issue
  logic [31:0] model_regs [32];
  int          legal_count;
  int          cycle;

  // Expected retirements, oldest first
  int          exp_due  [$];
  logic        exp_ill  [$];
  logic [4:0]  exp_rd   [$];
  logic [31:0] exp_data [$];

  // Stimulus scratch
  logic [31:0] r;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  prev1;
  logic [4:0]  prev2;

  kronos_exec_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .instret        (instret)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ========================================================================
  // Error handling
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // ========================================================================
  // Reference model, RV32I OP and OP-IMM semantics
  task automatic model_exec(input logic [31:0] w, output logic ill, output logic [31:0] res);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic        alt;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    alt = (f7 == F7_ALT);
    a   = model_regs[w[19:15]];
    b   = (opc == OPCODE_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if ((opc != OPCODE_OP) && (opc != OPCODE_OPIMM)) begin
      ill = 1'b1;
    end else if (opc == OPCODE_OP) begin
      ill = !((f7 == F7_BASE) || (alt && ((f3 == F3_ADD) || (f3 == F3_SR))));
    end else if (f3 == F3_SLL) begin
      ill = (f7 != F7_BASE);
    end else if (f3 == F3_SR) begin
      ill = !((f7 == F7_BASE) || alt);
    end else begin
      ill = 1'b0;
    end
    case (f3)
      F3_ADD:  res = ((opc == OPCODE_OP) && alt) ? a - b : a + b;
      F3_SLL:  res = a << b[4:0];
      F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  res = a ^ b;
      F3_OR:   res = a | b;
      F3_AND:  res = a & b;
      default: begin
        // Shift right, arithmetic fill for SRA and SRAI
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
    endcase
  endtask

  // ========================================================================
  // Instruction generators
  function automatic logic [4:0] rnd_reg();
    logic [31:0] v;
    v = $random(seed);
    return v[4:0];
  endfunction

  function automatic logic [31:0] gen_legal(input logic [4:0] d, s1, s2);
    logic [31:0] v;
    logic [2:0]  f3;
    logic [11:0] imm;
    v   = $random(seed);
    f3  = v[2:0];
    imm = v[19:8];
    if (v[4]) begin
      // OP, alternate funct7 only where it means SUB or SRA
      imm[11:5] = ((f3 == F3_ADD) || (f3 == F3_SR)) && v[3] ? F7_ALT : F7_BASE;
      return {imm[11:5], s2, s1, f3, d, OPCODE_OP};
    end
    // OP-IMM, shift immediates carry the funct7 pattern
    if (f3 == F3_SLL) begin
      imm[11:5] = F7_BASE;
    end else if (f3 == F3_SR) begin
      imm[11:5] = v[3] ? F7_ALT : F7_BASE;
    end
    return {imm, s1, f3, d, OPCODE_OPIMM};
  endfunction

  function automatic logic [31:0] gen_illegal(input logic [4:0] d, s1, s2);
    logic [31:0] v;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    v = $random(seed);
    case (v[1:0])
      2'd0: begin
        // Unknown major opcode
        opc = v[8:2];
        if ((opc == OPCODE_OP) || (opc == OPCODE_OPIMM)) begin
          opc[0] = ~opc[0];
        end
        return {v[31:15], v[11:9], d, opc};
      end
      2'd1: begin
        // funct7 neither base nor alternate
        f7 = v[15:9] | 7'h01;
        return {f7, s2, s1, v[18:16], d, OPCODE_OP};
      end
      2'd2: begin
        // Alternate funct7 on an operation without one
        f3 = v[11:9];
        if ((f3 == F3_ADD) || (f3 == F3_SR)) begin
          f3 = F3_XOR;
        end
        return {F7_ALT, s2, s1, f3, d, OPCODE_OP};
      end
      default: begin
        // Bad shift immediate upper bits
        f7 = v[2] ? F7_ALT : (v[15:9] | 7'h01);
        f3 = v[2] ? F3_SLL : F3_SR;
        return {f7, v[24:20], s1, f3, d, OPCODE_OPIMM};
      end
    endcase
  endfunction

  // ========================================================================
  // Cycle stepping, retire monitor and issue
  task automatic step_cycle();
    @(negedge clk);
    cycle++;
    if (dut_i.u_checker.fail_count != 0) begin
      stop_run("Pipeline checker assertion failed");
    end
    if (retire_valid) begin
      if (exp_due.size() == 0) begin
        stop_run("Retire pulse seen with no instruction in flight");
      end else begin
        check_eq(cycle, exp_due[0], "retire cycle");
        check_eq(retire_illegal, exp_ill[0], "retire_illegal");
        check_eq(retire_rd, exp_rd[0], "retire_rd");
        if (!exp_ill[0]) begin
          check_eq(retire_data, exp_data[0], "retire_data");
        end
        void'(exp_due.pop_front());
        void'(exp_ill.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
      end
    end else if ((exp_due.size() != 0) && (exp_due[0] <= cycle)) begin
      stop_run($sformatf("Retirement missing for instruction due in cycle %0d", exp_due[0]));
    end
  endtask

  task automatic issue(input logic [31:0] w);
    logic        ill;
    logic [31:0] res;
    step_cycle();
    model_exec(w, ill, res);
    if (!ill) begin
      legal_count++;
      if (w[11:7] != 5'd0) begin
        model_regs[w[11:7]] = res;
      end
    end
    exp_due.push_back(cycle + 2);
    exp_ill.push_back(ill);
    exp_rd.push_back(w[11:7]);
    exp_data.push_back(res);
    instr_valid = 1'b1;
    instr       = w;
  endtask

  // Bubble with a random word on the bus
  task automatic idle();
    step_cycle();
    instr_valid = 1'b0;
    instr       = $random(seed);
  endtask

  // ========================================================================
  // Stimulus
  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    legal_count = 0;
    cycle       = 0;
    prev1       = 5'd1;
    prev2       = 5'd2;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Independent random OP and OP-IMM, occasional bubbles
    for (int i = 0; i < 250; i++) begin
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        idle();
      end else begin
        issue(gen_legal(rnd_reg(), rnd_reg(), rnd_reg()));
      end
    end

    // Dependent chains over both forwarding levels
    for (int i = 0; i < 120; i++) begin
      r   = $random(seed);
      rs1 = r[0] ? prev1 : prev2;
      rs2 = r[1] ? prev2 : prev1;
      rd  = rnd_reg();
      issue(gen_legal(rd, rs1, rs2));
      prev2 = prev1;
      prev1 = rd;
    end

    // Writes to x0 mixed with reads of x0
    for (int i = 0; i < 40; i++) begin
      r   = $random(seed);
      rd  = r[0] ? 5'd0 : rnd_reg();
      rs1 = r[1] ? 5'd0 : prev1;
      rs2 = r[2] ? 5'd0 : rnd_reg();
      issue(gen_legal(rd, rs1, rs2));
      prev1 = rd;
    end

    // Illegal encodings aimed at the register the next instruction reads
    for (int i = 0; i < 100; i++) begin
      r  = $random(seed);
      rd = rnd_reg();
      if (r[1:0] == 2'd0) begin
        issue(gen_illegal(prev1, prev1, prev2));
      end else begin
        issue(gen_legal(rd, prev1, prev2));
        prev2 = prev1;
        prev1 = rd;
      end
    end

    // Drain the pipeline
    step_cycle();
    instr_valid = 1'b0;
    for (int t = 0; (t < 10) && (exp_due.size() != 0); t++) begin
      step_cycle();
    end
    if (exp_due.size() != 0) begin
      stop_run("Retirement missing after the last instruction");
    end
    check_eq(instret, legal_count, "instret");

    if (dut_i.u_checker.fail_count != 0) begin
      stop_run("Pipeline checker assertions failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== tests/kronos_exec_checker.sv ====
// ==========================================================================
// Kronos execute slice pipeline assertions
// ==========================================================================

`timescale 1ns/1ps

module kronos_exec_checker
  import kronos_types::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        instr_valid,
  input logic [31:0] instr,
  input logic        retire_valid,
  input logic        wr_en
);

  // Failed assertion count, read by the testbench every cycle
  int fail_count = 0;

  // Retire stage stays empty while in reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire_valid)
    else begin
      $error("retire_valid high during reset");
      fail_count++;
    end

  // Fixed two-cycle latency, no stalls
  retire_follows: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid |-> ##2 retire_valid)
    else begin
      $error("retire_valid missing two cycles after instr_valid");
      fail_count++;
    end

  retire_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    !instr_valid |-> ##2 !retire_valid)
    else begin
      $error("retire_valid without instr_valid two cycles earlier");
      fail_count++;
    end

  // An instruction for x0 or with an unknown opcode never writes
  // Its write slot is two edges after it is sampled
  write_guard: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid && ((instr[11:7] == '0) ||
      ((instr[6:0] != OPCODE_OP) && (instr[6:0] != OPCODE_OPIMM)))) |-> ##2 !wr_en)
    else begin
      $error("register write enabled for x0 or an illegal instruction");
      fail_count++;
    end

endmodule

bind kronos_exec_top kronos_exec_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .instr_valid  (instr_valid),
  .instr        (instr),
  .retire_valid (retire_valid),
  .wr_en        (wr_en)
);

// ==== source/kronos_exec_top.sv ====
// ==========================================================================
// Kronos two-stage execute slice
// ==========================================================================

`timescale 1ns/1ps

module kronos_exec_top
  import kronos_types::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic [31:0]           instr,
  output logic                  retire_valid,
  output logic                  retire_illegal,
  output logic [REG_ADDR_W-1:0] retire_rd,
  output logic [XLEN-1:0]       retire_data,
  output logic [XLEN-1:0]       instret
);

  // Decode stage
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  use_imm;
  logic [XLEN-1:0]       imm;

  // Execute stage
  logic                  ex_valid;
  logic                  ex_illegal;
  logic [ALUOP_W-1:0]    ex_aluop;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [XLEN-1:0]       ex_op1;
  logic [XLEN-1:0]       ex_op2;
  logic [XLEN-1:0]       ex_result;
  logic                  ex_fwd_valid;

  // Retire stage write port
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [XLEN-1:0]       wr_data;

  // Only a valid legal instruction in execute may forward
  assign ex_fwd_valid = ex_valid & ~ex_illegal;

  // ========================================================================
  // Control
  kronos_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .use_imm     (use_imm),
    .imm         (imm),
    .ex_valid    (ex_valid),
    .ex_illegal  (ex_illegal),
    .ex_aluop    (ex_aluop),
    .ex_rd       (ex_rd),
    // Source tags stay local to the decoder
    .ex_rs1      (),
    .ex_rs2      ()
  );

  // ========================================================================
  // Datapath
  kronos_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  // Retire forwarding uses the write port, rd 0 resolves to zero anyway
  kronos_operand u_operand (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .use_imm      (use_imm),
    .imm          (imm),
    .ex_fwd_valid (ex_fwd_valid),
    .ex_rd        (ex_rd),
    .ex_result    (ex_result),
    .rt_fwd_valid (wr_en),
    .rt_rd        (wr_addr),
    .rt_data      (wr_data),
    .ex_op1       (ex_op1),
    .ex_op2       (ex_op2)
  );

  kronos_alu u_alu (
    .op1    (ex_op1),
    .op2    (ex_op2),
    .aluop  (ex_aluop),
    .result (ex_result)
  );

  kronos_retire u_retire (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid       (ex_valid),
    .ex_illegal     (ex_illegal),
    .ex_rd          (ex_rd),
    .ex_result      (ex_result),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .instret        (instret)
  );

endmodule

// ==== source/kronos_retire.sv ====
// ==========================================================================
// Kronos retire stage
// ==========================================================================

`timescale 1ns/1ps

module kronos_retire
  import kronos_types::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid,
  input  logic                  ex_illegal,
  input  logic [REG_ADDR_W-1:0] ex_rd,
  input  logic [XLEN-1:0]       ex_result,
  output logic                  retire_valid,
  output logic                  retire_illegal,
  output logic [REG_ADDR_W-1:0] retire_rd,
  output logic [XLEN-1:0]       retire_data,
  output logic                  wr_en,
  output logic [REG_ADDR_W-1:0] wr_addr,
  output logic [XLEN-1:0]       wr_data,
  output logic [XLEN-1:0]       instret
);

  // Retire control and counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid   <= 1'b0;
      retire_illegal <= 1'b0;
      retire_rd      <= '0;
      instret        <= '0;
    end else begin
      retire_valid   <= ex_valid;
      retire_illegal <= ex_illegal;
      retire_rd      <= ex_rd;
      // Counts at the edge that raises retire_valid
      if (ex_valid && !ex_illegal) begin
        instret <= instret + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    retire_data <= ex_result;
  end

  // Register-file write, x0 and illegal encodings never write
  assign wr_en   = retire_valid && !retire_illegal && (retire_rd != '0);
  assign wr_addr = retire_rd;
  assign wr_data = retire_data;

endmodule

// ==== source/kronos_operand.sv ====
// ==========================================================================
// Kronos operand select and forwarding
// ==========================================================================

`timescale 1ns/1ps

module kronos_operand
  import kronos_types::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  input  logic [XLEN-1:0]       rs1_data,
  input  logic [XLEN-1:0]       rs2_data,
  input  logic                  use_imm,
  input  logic [XLEN-1:0]       imm,
  input  logic                  ex_fwd_valid,
  input  logic [REG_ADDR_W-1:0] ex_rd,
  input  logic [XLEN-1:0]       ex_result,
  input  logic                  rt_fwd_valid,
  input  logic [REG_ADDR_W-1:0] rt_rd,
  input  logic [XLEN-1:0]       rt_data,
  output logic [XLEN-1:0]       ex_op1,
  output logic [XLEN-1:0]       ex_op2
);

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] op2_next;

  // Source value with read-after-write resolution
  // Youngest producer wins, execute before retire before the array
  function automatic logic [XLEN-1:0] resolve(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data
  );
    if (addr == '0) begin
      return '0;
    end else if (ex_fwd_valid && (ex_rd == addr)) begin
      return ex_result;
    end else if (rt_fwd_valid && (rt_rd == addr)) begin
      return rt_data;
    end
    return rf_data;
  endfunction

  // ========================================================================
  // Operand select
  always_comb begin
    src1 = resolve(rs1_addr, rs1_data);
    src2 = resolve(rs2_addr, rs2_data);
  end

  // Immediate replaces op2, shifts only look at its low 5 bits
  assign op2_next = use_imm ? imm : src2;

  // ========================================================================
  // Execute-stage operand registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_op1 <= '0;
      ex_op2 <= '0;
    end else begin
      ex_op1 <= src1;
      ex_op2 <= op2_next;
    end
  end

endmodule

// ==== source/kronos_regfile.sv ====
// ==========================================================================
// Kronos integer register file
// ==========================================================================

`timescale 1ns/1ps

module kronos_regfile
  import kronos_types::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data,
  input  logic                  wr_en,
  input  logic [REG_ADDR_W-1:0] wr_addr,
  input  logic [XLEN-1:0]       wr_data
);

  // x0 is never written, so entry 0 stays at its reset value
  logic [XLEN-1:0] regs [REG_COUNT];

  // Write port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Asynchronous reads
  // Old contents until the write edge, forwarding covers the gap
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/kronos_decoder.sv ====
// ==========================================================================
// Kronos decoder and execute-stage control
// ==========================================================================

`timescale 1ns/1ps

module kronos_decoder
  import kronos_types::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  instr_t                instr,
  output logic [REG_ADDR_W-1:0] rs1_addr,
  output logic [REG_ADDR_W-1:0] rs2_addr,
  output logic                  use_imm,
  output logic [XLEN-1:0]       imm,
  output logic                  ex_valid,
  output logic                  ex_illegal,
  output logic [ALUOP_W-1:0]    ex_aluop,
  output logic [REG_ADDR_W-1:0] ex_rd,
  output logic [REG_ADDR_W-1:0] ex_rs1,
  output logic [REG_ADDR_W-1:0] ex_rs2
);

  logic                  is_op;
  logic                  is_opimm;
  logic [2:0]            funct3;
  logic [6:0]            upper7;
  logic [REG_ADDR_W-1:0] rd;
  logic [ALUOP_W-1:0]    aluop;
  logic                  illegal;

  // ========================================================================
  // Field extraction
  assign is_op    = (instr.r_type.opcode == OPCODE_OP);
  assign is_opimm = (instr.i_type.opcode == OPCODE_OPIMM);

  // Shared fields sit at the same bits in both views
  assign funct3 = instr.r_type.funct3;
  // funct7 for OP, upper immediate bits for OP-IMM
  assign upper7 = instr.r_type.funct7;
  assign rd     = instr.r_type.rd;

  // Register file addresses
  assign rs1_addr = instr.r_type.rs1;
  assign rs2_addr = instr.r_type.rs2;

  // Immediate path, sign-extended
  assign use_imm = is_opimm;
  assign imm     = {{(XLEN-12){instr.i_type.imm[11]}}, instr.i_type.imm};

  // ========================================================================
  // ALU operation and legality
  always_comb begin
    aluop   = ADD;
    illegal = 1'b0;

    case (funct3)
      // Register-immediate form never subtracts
      F3_ADD:  aluop = (is_op && upper7[5]) ? SUB : ADD;
      F3_SLL:  aluop = SLL;
      F3_SLT:  aluop = SLT;
      F3_SLTU: aluop = SLTU;
      F3_XOR:  aluop = XOR;
      F3_SR:   aluop = upper7[5] ? SRA : SRL;
      F3_OR:   aluop = OR;
      default: aluop = AND;
    endcase

    if (is_op) begin
      // Base funct7 is always fine, alternate only on ADD/SUB and SRL/SRA
      if (upper7 == F7_ALT) begin
        illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
      end else begin
        illegal = (upper7 != F7_BASE);
      end
    end else if (is_opimm) begin
      // Shift immediates carry a funct7 pattern in imm[11:5]
      if (funct3 == F3_SLL) begin
        illegal = (upper7 != F7_BASE);
      end else if (funct3 == F3_SR) begin
        illegal = (upper7 != F7_BASE) && (upper7 != F7_ALT);
      end
    end else begin
      // Any other major opcode
      illegal = 1'b1;
    end
  end

  // ========================================================================
  // Execute-stage control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid   <= 1'b0;
      ex_illegal <= 1'b0;
      ex_aluop   <= ADD;
      ex_rd      <= '0;
      ex_rs1     <= '0;
      ex_rs2     <= '0;
    end else begin
      ex_valid   <= instr_valid;
      ex_illegal <= illegal;
      ex_aluop   <= aluop;
      ex_rd      <= rd;
      ex_rs1     <= rs1_addr;
      // No second source for OP-IMM
      ex_rs2     <= is_op ? rs2_addr : '0;
    end
  end

endmodule

// ==== source/kronos_alu.sv ====
// ==========================================================================
// Kronos ALU
// ==========================================================================

`timescale 1ns/1ps

module kronos_alu
  import kronos_types::*;
(
  input  logic [XLEN-1:0]    op1,
  input  logic [XLEN-1:0]    op2,
  input  logic [ALUOP_W-1:0] aluop,
  output logic [XLEN-1:0]    result
);

  // Operation flags
  logic cin;
  logic rev;
  logic uns;

  // Per-function results
  logic [XLEN-1:0] r_adder;
  logic [XLEN-1:0] r_and;
  logic [XLEN-1:0] r_or;
  logic [XLEN-1:0] r_xor;
  logic [XLEN-1:0] r_shift;
  logic            r_comp;

  // Adder internals
  logic [XLEN-1:0] adder_b;
  logic            cout;

  // Comparator internals
  logic a_sign;
  logic b_sign;
  logic r_sign;
  logic r_lt;
  logic r_ltu;

  // Shifter internals
  logic [XLEN-1:0] sh_data;
  logic [4:0]      shamt;
  logic            shift_in;
  logic [XLEN-1:0] s0, s1, s2, s3, s4;

  // Bit reversal, turns the right shifter into a left shifter
  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] d);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = d[XLEN-1-i];
    end
    return r;
  endfunction

  // ========================================================================
  // Decode of the operation code
  assign cin = aluop[3];
  assign rev = aluop[2];
  assign uns = aluop[0];

  // ========================================================================
  // Shared adder
  // Inverted op2 plus carry-in gives subtraction
  always_comb begin
    adder_b = cin ? ~op2 : op2;
    {cout, r_adder} = {1'b0, op1} + {1'b0, adder_b} + {{XLEN{1'b0}}, cin};
  end

  // Bitwise logic
  always_comb begin
    r_and = op1 & op2;
    r_or  = op1 | op2;
    r_xor = op1 ^ op2;
  end

  // ========================================================================
  // Comparator, reads the subtraction op1 - op2 from the adder
  always_comb begin
    a_sign = op1[XLEN-1];
    b_sign = op2[XLEN-1];
    r_sign = r_adder[XLEN-1];

    // Same signs cannot overflow, so the difference sign decides
    // Mixed signs, the negative operand is the smaller one
    r_lt = (a_sign == b_sign) ? r_sign : a_sign;

    // No carry out means a borrow, op1 below op2 unsigned
    r_ltu = ~cout;

    r_comp = uns ? r_ltu : r_lt;
  end

  // ========================================================================
  // Barrel shifter
  // Five fixed right-shift levels, each fed by the previous one
  always_comb begin
    sh_data  = rev ? bit_rev(op1) : op1;
    // Arithmetic fill only for SRA
    shift_in = cin & op1[XLEN-1];
    shamt    = op2[4:0];

    s0 = shamt[0] ? {shift_in, sh_data[XLEN-1:1]} : sh_data;
    s1 = shamt[1] ? {{2{shift_in}}, s0[XLEN-1:2]} : s0;
    s2 = shamt[2] ? {{4{shift_in}}, s1[XLEN-1:4]} : s1;
    s3 = shamt[3] ? {{8{shift_in}}, s2[XLEN-1:8]} : s2;
    s4 = shamt[4] ? {{16{shift_in}}, s3[XLEN-1:16]} : s3;

    // Undo the reversal for left shifts
    r_shift = rev ? bit_rev(s4) : s4;
  end

  // ========================================================================
  // Result select
  always_comb begin
    unique case (aluop)
      SLT,
      SLTU: result = {{(XLEN-1){1'b0}}, r_comp};
      XOR:  result = r_xor;
      OR:   result = r_or;
      AND:  result = r_and;
      SLL,
      SRL,
      SRA:  result = r_shift;
      // ADD and SUB
      default: result = r_adder;
    endcase
  end

endmodule

// ==== source/kronos_types.sv ====
// ==========================================================================
// Kronos execute slice shared definitions
// ==========================================================================

package kronos_types;

  // ========================================================================
  // Widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_COUNT  = 32;
  localparam int ALUOP_W    = 4;

  // ========================================================================
  // ALU operation codes
  // Bit 3 carry-in / invert, bit 2 reverse, bit 0 unsigned
  localparam logic [ALUOP_W-1:0] ADD  = 4'b0000;
  localparam logic [ALUOP_W-1:0] XOR  = 4'b0010;
  localparam logic [ALUOP_W-1:0] OR   = 4'b0110;
  localparam logic [ALUOP_W-1:0] AND  = 4'b0111;
  localparam logic [ALUOP_W-1:0] SLL  = 4'b0100;
  localparam logic [ALUOP_W-1:0] SRL  = 4'b0001;
  localparam logic [ALUOP_W-1:0] SUB  = 4'b1000;
  localparam logic [ALUOP_W-1:0] SLT  = 4'b1100;
  localparam logic [ALUOP_W-1:0] SLTU = 4'b1101;
  localparam logic [ALUOP_W-1:0] SRA  = 4'b1001;

  // Major opcodes handled by this slice
  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;

  // funct3 field
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 field, also the upper immediate of shift immediates
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ========================================================================
  // Instruction word, R-type and I-type views of the same 32 bits
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r_type;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i_type;
  } instr_t;

endpackage
